//--- logic/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Instruction, PC and immediate width
`define DECODE_DATA_WIDTH 32

// General register file size and register address width
`define DECODE_GPR_NUM 32
`define DECODE_REG_ADDR_WIDTH $clog2(`DECODE_GPR_NUM)

// Encoded ALU control widths
`define DECODE_ALU_OP_WIDTH 8
`define DECODE_ALU_SEL_WIDTH 3

`endif

//--- logic/decode_pkg.sv
`include "decode_params.svh"

package decode_pkg;

    // Word from the fetch side together with its PC
    typedef struct packed {
        logic [`DECODE_DATA_WIDTH-1:0] instr;
        logic [`DECODE_DATA_WIDTH-1:0] pc;
    } instr_info_t;

    // 3R major opcodes, matched against instr[31:15]
    typedef enum logic [16:0] {
        op_add_w    = 17'h00020,
        op_sub_w    = 17'h00022,
        op_slt      = 17'h00024,
        op_sltu     = 17'h00025,
        op_nor      = 17'h00028,
        op_and      = 17'h00029,
        op_or       = 17'h0002a,
        op_xor      = 17'h0002b,
        op_sll_w    = 17'h0002e,
        op_srl_w    = 17'h0002f,
        op_sra_w    = 17'h00030,
        op_mul_w    = 17'h00038,
        op_mulh_w   = 17'h00039,
        op_mulh_wu  = 17'h0003a,
        op_div_w    = 17'h00040,
        op_mod_w    = 17'h00041,
        op_div_wu   = 17'h00042,
        op_mod_wu   = 17'h00043,
        op_break    = 17'h00054,
        op_syscall  = 17'h00056,
        op_idle     = 17'h00c91,
        op_invtlb   = 17'h00c93,
        op_dbar     = 17'h070e4,
        op_ibar     = 17'h070e5
    } op_3r_e;

    // 2RI12 opcodes, matched against instr[31:22]
    typedef enum logic [9:0] {
        op_slti   = 10'h008,
        op_sltui  = 10'h009,
        op_addi_w = 10'h00a,
        op_andi   = 10'h00d,
        op_ori    = 10'h00e,
        op_xori   = 10'h00f
    } op_2ri12_e;

    typedef enum logic [`DECODE_ALU_OP_WIDTH-1:0] {
        alu_nop     = 8'h00,
        alu_add     = 8'h01,
        alu_sub     = 8'h02,
        alu_slt     = 8'h03,
        alu_sltu    = 8'h04,
        alu_nor     = 8'h05,
        alu_and     = 8'h06,
        alu_or      = 8'h07,
        alu_xor     = 8'h08,
        alu_sll     = 8'h09,
        alu_srl     = 8'h0a,
        alu_sra     = 8'h0b,
        alu_mul     = 8'h0c,
        alu_mulh    = 8'h0d,
        alu_mulhu   = 8'h0e,
        alu_div     = 8'h0f,
        alu_divu    = 8'h10,
        alu_mod     = 8'h11,
        alu_modu    = 8'h12,
        alu_break   = 8'h13,
        alu_syscall = 8'h14,
        alu_idle    = 8'h15,
        alu_invtlb  = 8'h16
    } alu_op_e;

    // Result class picked by the execute stage
    typedef enum logic [`DECODE_ALU_SEL_WIDTH-1:0] {
        sel_nop   = 3'b000,
        sel_logic = 3'b001,
        sel_shift = 3'b010,
        sel_arith = 3'b100
    } alu_sel_e;

    typedef struct packed {
        // Bit 0 for rj, bit 1 for rk
        logic [1:0]                          reg_read_valid;
        // Packed as {rk, rj}
        logic [2*`DECODE_REG_ADDR_WIDTH-1:0] reg_read_addr;
        logic                                reg_write_valid;
        logic [`DECODE_REG_ADDR_WIDTH-1:0]   reg_write_addr;
        logic                                use_imm;
        logic [`DECODE_DATA_WIDTH-1:0]       imm;
        alu_op_e                             aluop;
        alu_sel_e                            alusel;
        logic                                instr_break;
        logic                                instr_syscall;
    } decode_result_t;

endpackage

//--- logic/decode_result_if.sv
`timescale 1ns/1ns

interface decode_result_if;
    import decode_pkg::*;

    // Decoder claims the current word
    logic           hit;
    // Decoded fields, only meaningful with hit
    decode_result_t result;

    modport dec (
        output hit,
        output result
    );

    modport stage (
        input hit,
        input result
    );

endinterface

//--- logic/decode_stage.sv
`timescale 1ns/1ns
`include "decode_params.svh"

module decode_stage (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          in_valid_i,
    output logic                          in_ready_o,
    input  logic [`DECODE_DATA_WIDTH-1:0] in_pc_i,
    decode_result_if.stage                res_3r,
    decode_result_if.stage                res_2ri12,
    output logic                          out_valid_o,
    input  logic                          out_ready_i,
    output logic [`DECODE_DATA_WIDTH-1:0] out_pc_o,
    output decode_pkg::decode_result_t    out_result_o,
    output logic                          out_illegal_o
);
    import decode_pkg::*;

    decode_result_t sel_result;
    logic           sel_illegal;
    logic           in_fire;

    // At most one decoder claims a word
    always_comb begin
        sel_illegal = 1'b0;
        if (res_3r.hit) begin
            sel_result = res_3r.result;
        end else if (res_2ri12.hit) begin
            sel_result = res_2ri12.result;
        end else begin
            sel_result  = '0;
            sel_illegal = 1'b1;
        end
    end

    // Accept when empty or when the held result leaves this cycle
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign in_fire    = in_valid_i && in_ready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_o   <= 1'b0;
            out_pc_o      <= '0;
            out_result_o  <= '0;
            out_illegal_o <= 1'b0;
        end else if (in_fire) begin
            out_valid_o   <= 1'b1;
            out_pc_o      <= in_pc_i;
            out_result_o  <= sel_result;
            out_illegal_o <= sel_illegal;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    // The two format decoders cover disjoint opcode spaces
    hit_exclusive_a: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        in_valid_i |-> !(res_3r.hit && res_2ri12.hit)
    ) else $error("decode_stage: both decoders claim the same word");

    // Held result must not change while the consumer stalls
    stall_stable_a: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (out_valid_o && !out_ready_i) |=>
            (out_valid_o && $stable(out_pc_o) && $stable(out_result_o)
             && $stable(out_illegal_o))
    ) else $error("decode_stage: output changed during stall");

endmodule

//--- logic/decode_top.sv
`timescale 1ns/1ns
`include "decode_params.svh"

module decode_top (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                in_valid_i,
    output logic                                in_ready_o,
    input  logic [`DECODE_DATA_WIDTH-1:0]       in_instr_i,
    input  logic [`DECODE_DATA_WIDTH-1:0]       in_pc_i,
    output logic                                out_valid_o,
    input  logic                                out_ready_i,
    output logic [`DECODE_DATA_WIDTH-1:0]       out_pc_o,
    output logic [1:0]                          out_reg_read_valid_o,
    output logic [2*`DECODE_REG_ADDR_WIDTH-1:0] out_reg_read_addr_o,
    output logic                                out_reg_write_valid_o,
    output logic [`DECODE_REG_ADDR_WIDTH-1:0]   out_reg_write_addr_o,
    output logic                                out_use_imm_o,
    output logic [`DECODE_DATA_WIDTH-1:0]       out_imm_o,
    output logic [`DECODE_ALU_OP_WIDTH-1:0]     out_aluop_o,
    output logic [`DECODE_ALU_SEL_WIDTH-1:0]    out_alusel_o,
    output logic                                out_break_o,
    output logic                                out_syscall_o,
    output logic                                out_illegal_o
);
    import decode_pkg::*;

    instr_info_t    instr_info;
    decode_result_t out_result;

    assign instr_info.instr = in_instr_i;
    assign instr_info.pc    = in_pc_i;

    // One result channel per format decoder
    decode_result_if res_3r_if ();
    decode_result_if res_2ri12_if ();

    decoder_3r decoder_3r_inst (
        .instr_info_i (instr_info),
        .res          (res_3r_if.dec)
    );

    decoder_2ri12 decoder_2ri12_inst (
        .instr_info_i (instr_info),
        .res          (res_2ri12_if.dec)
    );

    decode_stage decode_stage_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .in_pc_i       (in_pc_i),
        .res_3r        (res_3r_if.stage),
        .res_2ri12     (res_2ri12_if.stage),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .out_pc_o      (out_pc_o),
        .out_result_o  (out_result),
        .out_illegal_o (out_illegal_o)
    );

    // Flatten the registered result onto plain ports
    assign out_reg_read_valid_o  = out_result.reg_read_valid;
    assign out_reg_read_addr_o   = out_result.reg_read_addr;
    assign out_reg_write_valid_o = out_result.reg_write_valid;
    assign out_reg_write_addr_o  = out_result.reg_write_addr;
    assign out_use_imm_o         = out_result.use_imm;
    assign out_imm_o             = out_result.imm;
    assign out_aluop_o           = out_result.aluop;
    assign out_alusel_o          = out_result.alusel;
    assign out_break_o           = out_result.instr_break;
    assign out_syscall_o         = out_result.instr_syscall;

endmodule

//--- logic/decoder_2ri12.sv
`timescale 1ns/1ns
`include "decode_params.svh"

// 2RI12 format {opcode[10], si12[12], rj[5], rd[5]}
module decoder_2ri12 (
    input  decode_pkg::instr_info_t instr_info_i,
    decode_result_if.dec            res
);
    import decode_pkg::*;

    logic [`DECODE_DATA_WIDTH-1:0]     instr;
    logic [`DECODE_REG_ADDR_WIDTH-1:0] rd;
    logic [`DECODE_REG_ADDR_WIDTH-1:0] rj;
    logic [11:0]                       imm12;
    op_2ri12_e                         opcode;
    logic                              hit;
    logic                              sign_ext;
    decode_result_t                    dec;

    assign instr  = instr_info_i.instr;
    assign rd     = instr[4:0];
    assign rj     = instr[9:5];
    assign imm12  = instr[21:10];
    assign opcode = op_2ri12_e'(instr[31:22]);

    always_comb begin
        // Single read of rj, write of rd, immediate as second operand
        hit                 = 1'b1;
        sign_ext            = 1'b1;
        dec                 = '0;
        dec.reg_read_valid  = 2'b01;
        dec.reg_read_addr   = {{`DECODE_REG_ADDR_WIDTH{1'b0}}, rj};
        dec.reg_write_valid = 1'b1;
        dec.reg_write_addr  = rd;
        dec.use_imm         = 1'b1;
        dec.aluop           = alu_nop;
        dec.alusel          = sel_nop;

        case (opcode)
            op_addi_w: begin dec.aluop = alu_add;  dec.alusel = sel_arith; end
            op_slti:   begin dec.aluop = alu_slt;  dec.alusel = sel_arith; end
            op_sltui:  begin dec.aluop = alu_sltu; dec.alusel = sel_arith; end
            // Logic immediates are zero-extended
            op_andi:   begin dec.aluop = alu_and;  dec.alusel = sel_logic; sign_ext = 1'b0; end
            op_ori:    begin dec.aluop = alu_or;   dec.alusel = sel_logic; sign_ext = 1'b0; end
            op_xori:   begin dec.aluop = alu_xor;  dec.alusel = sel_logic; sign_ext = 1'b0; end
            default: begin
                hit = 1'b0;
                dec = '0;
            end
        endcase

        if (hit) begin
            dec.imm = sign_ext ? {{(`DECODE_DATA_WIDTH-12){imm12[11]}}, imm12}
                               : {{(`DECODE_DATA_WIDTH-12){1'b0}}, imm12};
        end
    end

    assign res.hit    = hit;
    assign res.result = dec;

endmodule

//--- logic/decoder_3r.sv
`timescale 1ns/1ns
`include "decode_params.svh"

// 3R format {opcode[17], rk[5], rj[5], rd[5]}
module decoder_3r (
    input  decode_pkg::instr_info_t instr_info_i,
    decode_result_if.dec            res
);
    import decode_pkg::*;

    logic [`DECODE_DATA_WIDTH-1:0]     instr;
    logic [`DECODE_REG_ADDR_WIDTH-1:0] rd;
    logic [`DECODE_REG_ADDR_WIDTH-1:0] rj;
    logic [`DECODE_REG_ADDR_WIDTH-1:0] rk;
    op_3r_e                            opcode;
    logic                              hit;
    logic                              no_regs;
    decode_result_t                    dec;

    assign instr  = instr_info_i.instr;
    assign rd     = instr[4:0];
    assign rj     = instr[9:5];
    assign rk     = instr[14:10];
    assign opcode = op_3r_e'(instr[31:15]);

    always_comb begin
        // Register-register form unless the opcode says otherwise
        hit                 = 1'b1;
        no_regs             = 1'b0;
        dec                 = '0;
        dec.reg_read_valid  = 2'b11;
        dec.reg_read_addr   = {rk, rj};
        dec.reg_write_valid = 1'b1;
        dec.reg_write_addr  = rd;
        dec.aluop           = alu_nop;
        dec.alusel          = sel_nop;

        case (opcode)
            op_break: begin
                no_regs         = 1'b1;
                dec.aluop       = alu_break;
                dec.instr_break = 1'b1;
            end
            op_syscall: begin
                no_regs = 1'b1;
                // Code 0x11 is the simulation stop marker, kept as a NOP
                if (instr[14:0] != 15'h11) begin
                    dec.aluop         = alu_syscall;
                    dec.instr_syscall = 1'b1;
                end
            end
            op_add_w:   begin dec.aluop = alu_add;   dec.alusel = sel_arith; end
            op_sub_w:   begin dec.aluop = alu_sub;   dec.alusel = sel_arith; end
            op_slt:     begin dec.aluop = alu_slt;   dec.alusel = sel_arith; end
            op_sltu:    begin dec.aluop = alu_sltu;  dec.alusel = sel_arith; end
            op_nor:     begin dec.aluop = alu_nor;   dec.alusel = sel_logic; end
            op_and:     begin dec.aluop = alu_and;   dec.alusel = sel_logic; end
            op_or:      begin dec.aluop = alu_or;    dec.alusel = sel_logic; end
            op_xor:     begin dec.aluop = alu_xor;   dec.alusel = sel_logic; end
            op_sll_w:   begin dec.aluop = alu_sll;   dec.alusel = sel_shift; end
            op_srl_w:   begin dec.aluop = alu_srl;   dec.alusel = sel_shift; end
            op_sra_w:   begin dec.aluop = alu_sra;   dec.alusel = sel_shift; end
            op_mul_w:   begin dec.aluop = alu_mul;   dec.alusel = sel_arith; end
            op_mulh_w:  begin dec.aluop = alu_mulh;  dec.alusel = sel_arith; end
            op_mulh_wu: begin dec.aluop = alu_mulhu; dec.alusel = sel_arith; end
            op_div_w:   begin dec.aluop = alu_div;   dec.alusel = sel_arith; end
            op_div_wu:  begin dec.aluop = alu_divu;  dec.alusel = sel_arith; end
            op_mod_w:   begin dec.aluop = alu_mod;   dec.alusel = sel_arith; end
            op_mod_wu:  begin dec.aluop = alu_modu;  dec.alusel = sel_arith; end
            op_idle, op_dbar, op_ibar: begin
                // Barriers are treated like idle for now
                dec.aluop  = alu_idle;
                dec.alusel = sel_nop;
            end
            op_invtlb: begin
                // rd field carries the invalidate op, not a register
                dec.aluop           = alu_invtlb;
                dec.use_imm         = 1'b1;
                dec.imm             = {{(`DECODE_DATA_WIDTH-5){1'b0}}, instr[4:0]};
                dec.reg_write_valid = 1'b0;
                dec.reg_write_addr  = '0;
            end
            default: begin
                // Not a 3R word
                hit = 1'b0;
                dec = '0;
            end
        endcase

        if (no_regs) begin
            dec.reg_read_valid  = 2'b00;
            dec.reg_read_addr   = '0;
            dec.reg_write_valid = 1'b0;
            dec.reg_write_addr  = '0;
        end
    end

    assign res.hit    = hit;
    assign res.result = dec;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_decode -f tb.f -o sim_decode
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_decode > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- tb.f
+incdir+logic
logic/decode_pkg.sv
logic/decode_result_if.sv
logic/decoder_3r.sv
logic/decoder_2ri12.sv
logic/decode_stage.sv
logic/decode_top.sv
test/decode_checker.sv
test/tb_decode.sv

//--- test/decode_cases.txt
# instr pc rd_valid rd_addr{rk,rj} wr_valid wr_addr use_imm imm aluop alusel break syscall illegal
# All columns in hex, one case per line
00101ca3 1c000000 3 0e5 1 03 0 00000000 01 4 0 0 0  # add.w
0011083f 1c000004 3 041 1 1f 0 00000000 02 4 0 0 0  # sub.w
00121ca3 1c000008 3 0e5 1 03 0 00000000 03 4 0 0 0  # slt
00129ca3 1c00000c 3 0e5 1 03 0 00000000 04 4 0 0 0  # sltu
00141ca3 1c000010 3 0e5 1 03 0 00000000 05 1 0 0 0  # nor
00149ca3 1c000014 3 0e5 1 03 0 00000000 06 1 0 0 0  # and
00151ca3 1c000018 3 0e5 1 03 0 00000000 07 1 0 0 0  # or
00159ca3 1c00001c 3 0e5 1 03 0 00000000 08 1 0 0 0  # xor
00171ca3 1c000020 3 0e5 1 03 0 00000000 09 2 0 0 0  # sll.w
00179ca3 1c000024 3 0e5 1 03 0 00000000 0a 2 0 0 0  # srl.w
00181ca3 1c000028 3 0e5 1 03 0 00000000 0b 2 0 0 0  # sra.w
001c1ca3 1c00002c 3 0e5 1 03 0 00000000 0c 4 0 0 0  # mul.w
001c9ca3 1c000030 3 0e5 1 03 0 00000000 0d 4 0 0 0  # mulh.w
001d1ca3 1c000034 3 0e5 1 03 0 00000000 0e 4 0 0 0  # mulh.wu
00201ca3 1c000038 3 0e5 1 03 0 00000000 0f 4 0 0 0  # div.w
00209ca3 1c00003c 3 0e5 1 03 0 00000000 11 4 0 0 0  # mod.w
00211ca3 1c000040 3 0e5 1 03 0 00000000 10 4 0 0 0  # div.wu
00219ca3 1c000044 3 0e5 1 03 0 00000000 12 4 0 0 0  # mod.wu
002a0000 1c000048 0 000 0 00 0 00000000 13 0 1 0 0  # break 0
002b0005 1c00004c 0 000 0 00 0 00000000 14 0 0 1 0  # syscall 5
002b0011 1c000050 0 000 0 00 0 00000000 00 0 0 0 0  # syscall 0x11 stop marker
06499045 1c000054 3 082 0 00 1 00000005 16 0 0 0 0  # invtlb op 5
06488000 1c000058 3 000 1 00 0 00000000 15 0 0 0 0  # idle
38720000 1c00005c 3 000 1 00 0 00000000 15 0 0 0 0  # dbar
38728000 1c000060 3 000 1 00 0 00000000 15 0 0 0 0  # ibar
02a000a3 1c000064 1 005 1 03 1 fffff800 01 4 0 0 0  # addi.w -2048
023ffc22 1c000068 1 001 1 02 1 ffffffff 03 4 0 0 0  # slti -1
025ffca3 1c00006c 1 005 1 03 1 000007ff 04 4 0 0 0  # sltui 0x7ff
036af0a3 1c000070 1 005 1 03 1 00000abc 06 1 0 0 0  # andi 0xabc
03a000a3 1c000074 1 005 1 03 1 00000800 07 1 0 0 0  # ori 0x800
03fffca3 1c000078 1 005 1 03 1 00000fff 08 1 0 0 0  # xori 0xfff
ffffffff 1c00007c 0 000 0 00 0 00000000 00 0 0 0 1  # unknown
00000000 1c000080 0 000 0 00 0 00000000 00 0 0 0 1  # unknown

//--- test/decode_checker.sv
`timescale 1ns/1ns
`include "decode_params.svh"

module decode_checker (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                valid_i,
    input  logic                                ready_i,
    input  logic                                in_ready_i,
    input  logic [`DECODE_DATA_WIDTH-1:0]       pc_i,
    input  logic [1:0]                          read_valid_i,
    input  logic [2*`DECODE_REG_ADDR_WIDTH-1:0] read_addr_i,
    input  logic                                write_valid_i,
    input  logic [`DECODE_REG_ADDR_WIDTH-1:0]   write_addr_i,
    input  logic                                use_imm_i,
    input  logic [`DECODE_DATA_WIDTH-1:0]       imm_i,
    input  logic [`DECODE_ALU_OP_WIDTH-1:0]     aluop_i,
    input  logic [`DECODE_ALU_SEL_WIDTH-1:0]    alusel_i,
    input  logic                                break_i,
    input  logic                                syscall_i,
    input  logic                                illegal_i,
    output int                                  total_cases_o,
    output int                                  seen_count_o,
    output int                                  pass_count_o,
    output int                                  error_count_o
);
    localparam int num_cols  = 13;
    localparam int max_cases = 64;

    logic [31:0] expected [0:max_cases-1][0:num_cols-1];
    logic [96:0] now_fields;
    logic [96:0] held;
    logic        stalled     = 1'b0;
    logic        reset_done  = 1'b0;
    int          seen        = 0;
    int          passed      = 0;
    int          errors      = 0;
    int          case_errors = 0;

    // Every output that must hold while the consumer stalls
    assign now_fields = {pc_i, read_valid_i, read_addr_i, write_valid_i, write_addr_i,
                         use_imm_i, imm_i, aluop_i, alusel_i, break_i, syscall_i, illegal_i};

    initial begin
        int          fd;
        int          n;
        int          k;
        logic [31:0] col [0:num_cols-1];
        string       line;
        n = 0;
        fd = $fopen("test/decode_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: checker cannot open test/decode_cases.txt");
        end else begin
            while (!$feof(fd) && n < max_cases) begin
                line = "";
                if ($fgets(line, fd) != 0 &&
                    $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                            col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                            col[7], col[8], col[9], col[10], col[11], col[12]) == num_cols) begin
                    for (k = 0; k < num_cols; k++) begin
                        expected[n][k] = col[k];
                    end
                    n++;
                end
            end
            $fclose(fd);
        end
        total_cases_o = n;
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            case_errors++;
        end
    endtask

    task automatic check_result(input int idx);
        case_errors = 0;
        compare_field("out_pc_o", pc_i, expected[idx][1]);
        compare_field("out_reg_read_valid_o", 32'(read_valid_i), expected[idx][2]);
        compare_field("out_reg_read_addr_o", 32'(read_addr_i), expected[idx][3]);
        compare_field("out_reg_write_valid_o", 32'(write_valid_i), expected[idx][4]);
        compare_field("out_reg_write_addr_o", 32'(write_addr_i), expected[idx][5]);
        compare_field("out_use_imm_o", 32'(use_imm_i), expected[idx][6]);
        compare_field("out_imm_o", imm_i, expected[idx][7]);
        compare_field("out_aluop_o", 32'(aluop_i), expected[idx][8]);
        compare_field("out_alusel_o", 32'(alusel_i), expected[idx][9]);
        compare_field("out_break_o", 32'(break_i), expected[idx][10]);
        compare_field("out_syscall_o", 32'(syscall_i), expected[idx][11]);
        compare_field("out_illegal_o", 32'(illegal_i), expected[idx][12]);
        if (case_errors == 0) begin
            passed++;
        end
        errors += case_errors;
        $display("case %0d instr %h pc %h: %s", idx, expected[idx][0], expected[idx][1],
                 case_errors == 0 ? "ok" : "FAIL");
    endtask

    always @(posedge clk) begin
        if (arst_n_i) begin
            // First edge out of reset, result register must be empty
            if (!reset_done) begin
                if (valid_i || break_i || syscall_i || illegal_i) begin
                    $display("ERROR at %0t ns: outputs not cleared after reset", $time);
                    errors++;
                end
                reset_done = 1'b1;
            end
            // An empty or draining output register must take a new word
            if ((!valid_i || ready_i) && in_ready_i !== 1'b1) begin
                $display("MISMATCH at %0t ns: in_ready_o got %b expected 1", $time, in_ready_i);
                errors++;
            end
            if (stalled && now_fields !== held) begin
                $display("ERROR at %0t ns: outputs changed while the consumer stalled", $time);
                errors++;
            end
            stalled = valid_i && !ready_i;
            held    = now_fields;
            if (valid_i && ready_i) begin
                if (seen >= total_cases_o) begin
                    $display("ERROR at %0t ns: result beyond the last case, pc %h", $time, pc_i);
                    errors++;
                end else begin
                    check_result(seen);
                end
                seen++;
            end
        end
        seen_count_o  <= seen;
        pass_count_o  <= passed;
        error_count_o <= errors;
    end

endmodule

//--- test/tb_decode.sv
`timescale 1ns/1ns
`include "decode_params.svh"

module tb_decode;

    localparam int num_cols  = 13;
    localparam int max_cases = 64;
    // Cycles any single wait may take
    localparam int wait_limit = 200;

    logic                                clk;
    logic                                arst_n_i;
    logic                                in_valid_i;
    logic                                in_ready_o;
    logic [`DECODE_DATA_WIDTH-1:0]       in_instr_i;
    logic [`DECODE_DATA_WIDTH-1:0]       in_pc_i;
    logic                                out_valid_o;
    logic                                out_ready_i;
    logic [`DECODE_DATA_WIDTH-1:0]       out_pc_o;
    logic [1:0]                          out_reg_read_valid_o;
    logic [2*`DECODE_REG_ADDR_WIDTH-1:0] out_reg_read_addr_o;
    logic                                out_reg_write_valid_o;
    logic [`DECODE_REG_ADDR_WIDTH-1:0]   out_reg_write_addr_o;
    logic                                out_use_imm_o;
    logic [`DECODE_DATA_WIDTH-1:0]       out_imm_o;
    logic [`DECODE_ALU_OP_WIDTH-1:0]     out_aluop_o;
    logic [`DECODE_ALU_SEL_WIDTH-1:0]    out_alusel_o;
    logic                                out_break_o;
    logic                                out_syscall_o;
    logic                                out_illegal_o;

    int          total_cases;
    int          seen_count;
    int          pass_count;
    int          error_count;
    int          num_stim;
    logic        timed_out;
    logic [31:0] stim_instr [0:max_cases-1];
    logic [31:0] stim_pc [0:max_cases-1];

    decode_top decode_top_inst (
        .clk                   (clk),
        .arst_n_i              (arst_n_i),
        .in_valid_i            (in_valid_i),
        .in_ready_o            (in_ready_o),
        .in_instr_i            (in_instr_i),
        .in_pc_i               (in_pc_i),
        .out_valid_o           (out_valid_o),
        .out_ready_i           (out_ready_i),
        .out_pc_o              (out_pc_o),
        .out_reg_read_valid_o  (out_reg_read_valid_o),
        .out_reg_read_addr_o   (out_reg_read_addr_o),
        .out_reg_write_valid_o (out_reg_write_valid_o),
        .out_reg_write_addr_o  (out_reg_write_addr_o),
        .out_use_imm_o         (out_use_imm_o),
        .out_imm_o             (out_imm_o),
        .out_aluop_o           (out_aluop_o),
        .out_alusel_o          (out_alusel_o),
        .out_break_o           (out_break_o),
        .out_syscall_o         (out_syscall_o),
        .out_illegal_o         (out_illegal_o)
    );

    decode_checker decode_checker_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .valid_i       (out_valid_o),
        .ready_i       (out_ready_i),
        .in_ready_i    (in_ready_o),
        .pc_i          (out_pc_o),
        .read_valid_i  (out_reg_read_valid_o),
        .read_addr_i   (out_reg_read_addr_o),
        .write_valid_i (out_reg_write_valid_o),
        .write_addr_i  (out_reg_write_addr_o),
        .use_imm_i     (out_use_imm_o),
        .imm_i         (out_imm_o),
        .aluop_i       (out_aluop_o),
        .alusel_i      (out_alusel_o),
        .break_i       (out_break_o),
        .syscall_i     (out_syscall_o),
        .illegal_i     (out_illegal_o),
        .total_cases_o (total_cases),
        .seen_count_o  (seen_count),
        .pass_count_o  (pass_count),
        .error_count_o (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Random back-pressure from the consumer
    initial begin
        out_ready_i = 1'b0;
        forever begin
            @(posedge clk);
            out_ready_i <= ($urandom % 3) != 0;
        end
    end

    task automatic read_stimulus();
        int          fd;
        logic [31:0] col [0:num_cols-1];
        string       line;
        num_stim = 0;
        fd = $fopen("test/decode_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open test/decode_cases.txt");
        end else begin
            while (!$feof(fd) && num_stim < max_cases) begin
                line = "";
                if ($fgets(line, fd) != 0 &&
                    $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                            col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                            col[7], col[8], col[9], col[10], col[11], col[12]) == num_cols) begin
                    stim_instr[num_stim] = col[0];
                    stim_pc[num_stim]    = col[1];
                    num_stim++;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int unsigned gap;
        int          waited;
        int          i;
        logic        accepted;
        arst_n_i   = 1'b0;
        in_valid_i = 1'b0;
        in_instr_i = '0;
        in_pc_i    = '0;
        timed_out  = 1'b0;
        void'($urandom(34521));
        read_stimulus();

        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;

        i = 0;
        while (i < num_stim && !timed_out) begin
            // Random idle cycles before the next word
            gap = $urandom % 3;
            repeat (gap) begin
                in_valid_i <= 1'b0;
                @(posedge clk);
            end
            in_valid_i <= 1'b1;
            in_instr_i <= stim_instr[i];
            in_pc_i    <= stim_pc[i];
            // Word moves on the first edge that sees in_ready_o high
            waited   = 0;
            accepted = 1'b0;
            while (!accepted && waited < wait_limit) begin
                @(posedge clk);
                accepted = in_ready_o;
                waited++;
            end
            if (!accepted) begin
                $display("TIMEOUT: in_ready_o stayed low for %0d cycles on case %0d", waited, i);
                timed_out = 1'b1;
            end
            i++;
        end
        in_valid_i <= 1'b0;

        // Drain until the checker has seen every result
        waited = 0;
        while (!timed_out && seen_count < num_stim && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (!timed_out && seen_count < num_stim) begin
            $display("TIMEOUT: only %0d of %0d results arrived", seen_count, num_stim);
            timed_out = 1'b1;
        end
        // Quiet period to catch stray results
        repeat (2) @(posedge clk);

        if (num_stim == 0) begin
            $display("ERROR: no cases were read from test/decode_cases.txt");
        end
        $display("Summary: %0d cases, %0d results seen, %0d passed, %0d errors",
                 total_cases, seen_count, pass_count, error_count);
        if (timed_out || num_stim == 0 || error_count != 0 || seen_count != total_cases
            || pass_count != num_stim) begin
            $display("Done: errors found");
        end else begin
            $display("Done: no errors");
        end
        $finish;
    end

endmodule
